// File: hdu_pkg.sv
/* shared types and constants for the dual-issue hazard detection unit,
   referenced by scoped name from every RTL block */
package hdu_pkg;

    // architectural register file is 32 entries
    localparam int REG_ADDR_W = 5;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // execution unit class, stored per slot for the WAW rule
    typedef enum logic [2:0] {
        ALU = 3'd0,
        MUL = 3'd1,
        DIV = 3'd2,
        CSR = 3'd3,
        LSU = 3'd4
    } ex_unit_e;

    localparam int DEFAULT_SLOTS = 8; // scoreboard depth unless overridden

endpackage

// File: hdu_scoreboard.sv
/* slot table of in-flight register writes; filled by issue, cleared by the
   dual commit port, provides occupied and live masks plus per-slot rd/unit */
`timescale 1ns/1ns

module hdu_scoreboard #(
    parameter int  NUM_SLOTS = hdu_pkg::DEFAULT_SLOTS,
    localparam int ID_W      = $clog2(NUM_SLOTS),
    localparam int UNIT_W    = $bits(hdu_pkg::ex_unit_e)
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     commit_valid_i,
    input  logic [ID_W-1:0]                          commit_id_i,
    input  logic                                     commit2_valid_i,
    input  logic [ID_W-1:0]                          commit2_id_i,
    input  logic [1:0]                               issue_i,
    input  logic [ID_W-1:0]                          inst1_id_i,
    input  logic [ID_W-1:0]                          inst2_id_i,
    input  logic                                     inst1_wr_i,
    input  logic                                     inst2_wr_i,
    input  hdu_pkg::reg_addr_t                       inst1_rd_i,
    input  hdu_pkg::reg_addr_t                       inst2_rd_i,
    input  hdu_pkg::ex_unit_e                        inst1_unit_i,
    input  hdu_pkg::ex_unit_e                        inst2_unit_i,
    output logic [NUM_SLOTS-1:0]                     occupied_o,
    output logic [NUM_SLOTS-1:0]                     live_o,
    output logic [NUM_SLOTS*hdu_pkg::REG_ADDR_W-1:0] slot_rd_o,
    output logic [NUM_SLOTS*UNIT_W-1:0]              slot_unit_o,
    output logic                                     lock_o
);

    logic [NUM_SLOTS-1:0] occupied;
    logic [NUM_SLOTS-1:0] commit_mask;    // slots named on either commit port
    hdu_pkg::reg_addr_t   slot_rd [NUM_SLOTS];
    hdu_pkg::ex_unit_e    slot_unit [NUM_SLOTS];

    logic fill1;
    logic fill2;

    assign fill1 = issue_i[0] && inst1_wr_i;
    assign fill2 = issue_i[1] && inst2_wr_i;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        assign commit_mask[i] = (commit_valid_i && (commit_id_i == ID_W'(i))) ||
                                (commit2_valid_i && (commit2_id_i == ID_W'(i)));
        assign slot_rd_o[i*hdu_pkg::REG_ADDR_W +: hdu_pkg::REG_ADDR_W] = slot_rd[i];
        assign slot_unit_o[i*UNIT_W +: UNIT_W] = slot_unit[i];
    end

    // clear first so a fill to the same slot overrides the commit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;
        end else begin
            occupied <= occupied & ~commit_mask;
            if (fill1) begin
                occupied[inst1_id_i] <= 1'b1;
            end
            if (fill2) begin
                occupied[inst2_id_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill1) begin
            slot_rd[inst1_id_i]   <= inst1_rd_i;
            slot_unit[inst1_id_i] <= inst1_unit_i;
        end
        if (fill2) begin
            slot_rd[inst2_id_i]   <= inst2_rd_i;
            slot_unit[inst2_id_i] <= inst2_unit_i;
        end
    end

    assign occupied_o = occupied;
    assign live_o     = occupied & ~commit_mask; // committing slots stop counting now
    assign lock_o     = |occupied;

endmodule

// File: hdu_slot_alloc.sv
/* free-slot search for the dual-issue scoreboard: picks two slot IDs and
   flags whether at least two credits (free slots) remain */
`timescale 1ns/1ns

module hdu_slot_alloc #(
    parameter int  NUM_SLOTS = hdu_pkg::DEFAULT_SLOTS,
    localparam int ID_W      = $clog2(NUM_SLOTS),
    localparam int CNT_W     = $clog2(NUM_SLOTS + 1)
) (
    input  logic [NUM_SLOTS-1:0] occupied_i,
    output logic [ID_W-1:0]      free_id1_o,
    output logic [ID_W-1:0]      free_id2_o,
    output logic                 credit_ok_o
);

    logic [CNT_W-1:0] free_cnt;

    // lowest free slot
    always_comb begin : p_id1
        logic found;
        found      = 1'b0;
        free_id1_o = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (!found && !occupied_i[i]) begin
                free_id1_o = ID_W'(i);
                found      = 1'b1;
            end
        end
    end

    // next free slot after id1, wrapping round the table
    always_comb begin : p_id2
        logic found;
        int   idx;
        found      = 1'b0;
        free_id2_o = '0;
        for (int k = 1; k < NUM_SLOTS; k++) begin
            idx = (int'(free_id1_o) + k) % NUM_SLOTS;
            if (!found && !occupied_i[idx]) begin
                free_id2_o = ID_W'(idx);
                found      = 1'b1;
            end
        end
    end

    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            free_cnt = free_cnt + CNT_W'(!occupied_i[i]);
        end
    end

    assign credit_ok_o = (free_cnt >= CNT_W'(2)); // room for a full pair

endmodule

// File: hdu_hazard_check.sv
/* RAW and WAW detection of the issue pair against live scoreboard slots,
   plus the dependency check of inst2 on inst1 */
`timescale 1ns/1ns

module hdu_hazard_check #(
    parameter int  NUM_SLOTS = hdu_pkg::DEFAULT_SLOTS,
    localparam int RW        = hdu_pkg::REG_ADDR_W,
    localparam int UNIT_W    = $bits(hdu_pkg::ex_unit_e)
) (
    input  logic                        inst1_valid_i,
    input  hdu_pkg::reg_addr_t          inst1_rd_i,
    input  hdu_pkg::reg_addr_t          inst1_rs1_i,
    input  hdu_pkg::reg_addr_t          inst1_rs2_i,
    input  logic                        inst1_rd_we_i,
    input  hdu_pkg::ex_unit_e           inst1_unit_i,
    input  logic                        inst2_valid_i,
    input  hdu_pkg::reg_addr_t          inst2_rd_i,
    input  hdu_pkg::reg_addr_t          inst2_rs1_i,
    input  hdu_pkg::reg_addr_t          inst2_rs2_i,
    input  logic                        inst2_rd_we_i,
    input  hdu_pkg::ex_unit_e           inst2_unit_i,
    input  logic [NUM_SLOTS-1:0]        live_i,
    input  logic [NUM_SLOTS*RW-1:0]     slot_rd_i,
    input  logic [NUM_SLOTS*UNIT_W-1:0] slot_unit_i,
    output logic                        inst1_wr_o,
    output logic                        inst2_wr_o,
    output logic                        inst1_table_hazard_o,
    output logic                        inst2_table_hazard_o,
    output logic                        pair_hazard_o
);

    // one instruction against every live slot
    function automatic logic table_hazard(
        input logic                        valid,
        input logic                        wr,
        input hdu_pkg::reg_addr_t          rd,
        input hdu_pkg::reg_addr_t          rs1,
        input hdu_pkg::reg_addr_t          rs2,
        input hdu_pkg::ex_unit_e           unit,
        input logic [NUM_SLOTS-1:0]        live,
        input logic [NUM_SLOTS*RW-1:0]     tbl_rd,
        input logic [NUM_SLOTS*UNIT_W-1:0] tbl_unit
    );
        logic               hit;
        hdu_pkg::reg_addr_t srd;
        logic               raw;
        logic               waw;
        hit = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            srd = tbl_rd[i*RW +: RW];
            raw = valid && (((rs1 != '0) && (rs1 == srd)) || ((rs2 != '0) && (rs2 == srd)));
            // same unit retires in order, so only a class change is a WAW
            waw = wr && (rd == srd) && (unit != hdu_pkg::ex_unit_e'(tbl_unit[i*UNIT_W +: UNIT_W]));
            hit = hit | (live[i] && (raw || waw));
        end
        return hit;
    endfunction

    assign inst1_wr_o = inst1_valid_i && inst1_rd_we_i && (inst1_rd_i != '0);
    assign inst2_wr_o = inst2_valid_i && inst2_rd_we_i && (inst2_rd_i != '0);

    assign inst1_table_hazard_o = table_hazard(inst1_valid_i, inst1_wr_o, inst1_rd_i,
                                               inst1_rs1_i, inst1_rs2_i, inst1_unit_i,
                                               live_i, slot_rd_i, slot_unit_i);
    assign inst2_table_hazard_o = table_hazard(inst2_valid_i, inst2_wr_o, inst2_rd_i,
                                               inst2_rs1_i, inst2_rs2_i, inst2_unit_i,
                                               live_i, slot_rd_i, slot_unit_i);

    // inst1 rd is never x0 here, so a match implies a real source
    assign pair_hazard_o = inst1_wr_o && inst2_valid_i &&
                           ((inst2_rs1_i == inst1_rd_i) || (inst2_rs2_i == inst1_rd_i) ||
                            (inst2_wr_o && (inst2_rd_i == inst1_rd_i)));

endmodule

// File: hdu_issue_ctrl.sv
/* issue decision for the instruction pair (none, first only, both) and
   gating of the allocated slot IDs */
`timescale 1ns/1ns

module hdu_issue_ctrl #(
    parameter int  NUM_SLOTS = hdu_pkg::DEFAULT_SLOTS,
    localparam int ID_W      = $clog2(NUM_SLOTS)
) (
    input  logic            inst1_valid_i,
    input  logic            inst2_valid_i,
    input  logic            credit_ok_i,
    input  logic            irq_req_i,
    input  logic            inst1_jump_i,
    input  logic            inst1_branch_i,
    input  logic            inst1_table_hazard_i,
    input  logic            inst2_table_hazard_i,
    input  logic            pair_hazard_i,
    input  logic [ID_W-1:0] free_id1_i,
    input  logic [ID_W-1:0] free_id2_i,
    output logic [1:0]      issue_o,
    output logic [ID_W-1:0] inst1_id_o,
    output logic [ID_W-1:0] inst2_id_o
);

    logic stall_all;
    logic first_only;

    assign stall_all  = !credit_ok_i || irq_req_i || inst1_table_hazard_i;
    // control flow in inst1 serializes the pair
    assign first_only = inst1_jump_i || inst1_branch_i || inst2_table_hazard_i ||
                        pair_hazard_i;

    always_comb begin
        if (stall_all) begin
            issue_o = 2'b00;
        end else if (first_only) begin
            issue_o = 2'b01;
        end else begin
            issue_o = 2'b11;
        end
    end

    assign inst1_id_o = (issue_o[0] && inst1_valid_i) ? free_id1_i : '0;
    assign inst2_id_o = (issue_o[1] && inst2_valid_i) ? free_id2_i : '0;

endmodule

// File: hdu_top.sv
/* dual-issue hazard detection unit; scoreboard, slot allocator, hazard
   check and issue control wired together, combinational issue path */
`timescale 1ns/1ns

module hdu_top #(
    parameter int  NUM_SLOTS = hdu_pkg::DEFAULT_SLOTS,
    localparam int ID_W      = $clog2(NUM_SLOTS),
    localparam int UNIT_W    = $bits(hdu_pkg::ex_unit_e)
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst1_valid_i,
    input  hdu_pkg::reg_addr_t inst1_rd_i,
    input  hdu_pkg::reg_addr_t inst1_rs1_i,
    input  hdu_pkg::reg_addr_t inst1_rs2_i,
    input  logic               inst1_rd_we_i,
    input  hdu_pkg::ex_unit_e  inst1_unit_i,
    input  logic               inst2_valid_i,
    input  hdu_pkg::reg_addr_t inst2_rd_i,
    input  hdu_pkg::reg_addr_t inst2_rs1_i,
    input  hdu_pkg::reg_addr_t inst2_rs2_i,
    input  logic               inst2_rd_we_i,
    input  hdu_pkg::ex_unit_e  inst2_unit_i,
    input  logic               commit_valid_i,
    input  logic [ID_W-1:0]    commit_id_i,
    input  logic               commit2_valid_i,
    input  logic [ID_W-1:0]    commit2_id_i,
    input  logic               irq_req_i,
    input  logic               inst1_jump_i,
    input  logic               inst1_branch_i,
    output logic [1:0]         issue_o,
    output logic [ID_W-1:0]    inst1_id_o,
    output logic [ID_W-1:0]    inst2_id_o,
    output logic               lock_o
);

    logic [NUM_SLOTS-1:0]                     occupied;
    logic [NUM_SLOTS-1:0]                     live;
    logic [NUM_SLOTS*hdu_pkg::REG_ADDR_W-1:0] slot_rd;
    logic [NUM_SLOTS*UNIT_W-1:0]              slot_unit;
    logic [ID_W-1:0]                          free_id1;
    logic [ID_W-1:0]                          free_id2;
    logic                                     credit_ok;
    logic                                     inst1_wr;
    logic                                     inst2_wr;
    logic                                     inst1_table_hazard;
    logic                                     inst2_table_hazard;
    logic                                     pair_hazard;

    // issue decision and gated IDs loop back as the fill command
    hdu_scoreboard #(.NUM_SLOTS(NUM_SLOTS)) i_hdu_scoreboard (
        .clk             (clk),
        .rst_n           (rst_n),
        .commit_valid_i  (commit_valid_i),
        .commit_id_i     (commit_id_i),
        .commit2_valid_i (commit2_valid_i),
        .commit2_id_i    (commit2_id_i),
        .issue_i         (issue_o),
        .inst1_id_i      (inst1_id_o),
        .inst2_id_i      (inst2_id_o),
        .inst1_wr_i      (inst1_wr),
        .inst2_wr_i      (inst2_wr),
        .inst1_rd_i      (inst1_rd_i),
        .inst2_rd_i      (inst2_rd_i),
        .inst1_unit_i    (inst1_unit_i),
        .inst2_unit_i    (inst2_unit_i),
        .occupied_o      (occupied),
        .live_o          (live),
        .slot_rd_o       (slot_rd),
        .slot_unit_o     (slot_unit),
        .lock_o          (lock_o)
    );

    hdu_slot_alloc #(.NUM_SLOTS(NUM_SLOTS)) i_hdu_slot_alloc (
        .occupied_i  (occupied),   // not live, commits free slots one edge later
        .free_id1_o  (free_id1),
        .free_id2_o  (free_id2),
        .credit_ok_o (credit_ok)
    );

    hdu_hazard_check #(.NUM_SLOTS(NUM_SLOTS)) i_hdu_hazard_check (
        .inst1_valid_i        (inst1_valid_i),
        .inst1_rd_i           (inst1_rd_i),
        .inst1_rs1_i          (inst1_rs1_i),
        .inst1_rs2_i          (inst1_rs2_i),
        .inst1_rd_we_i        (inst1_rd_we_i),
        .inst1_unit_i         (inst1_unit_i),
        .inst2_valid_i        (inst2_valid_i),
        .inst2_rd_i           (inst2_rd_i),
        .inst2_rs1_i          (inst2_rs1_i),
        .inst2_rs2_i          (inst2_rs2_i),
        .inst2_rd_we_i        (inst2_rd_we_i),
        .inst2_unit_i         (inst2_unit_i),
        .live_i               (live),
        .slot_rd_i            (slot_rd),
        .slot_unit_i          (slot_unit),
        .inst1_wr_o           (inst1_wr),
        .inst2_wr_o           (inst2_wr),
        .inst1_table_hazard_o (inst1_table_hazard),
        .inst2_table_hazard_o (inst2_table_hazard),
        .pair_hazard_o        (pair_hazard)
    );

    hdu_issue_ctrl #(.NUM_SLOTS(NUM_SLOTS)) i_hdu_issue_ctrl (
        .inst1_valid_i        (inst1_valid_i),
        .inst2_valid_i        (inst2_valid_i),
        .credit_ok_i          (credit_ok),
        .irq_req_i            (irq_req_i),
        .inst1_jump_i         (inst1_jump_i),
        .inst1_branch_i       (inst1_branch_i),
        .inst1_table_hazard_i (inst1_table_hazard),
        .inst2_table_hazard_i (inst2_table_hazard),
        .pair_hazard_i        (pair_hazard),
        .free_id1_i           (free_id1),
        .free_id2_i           (free_id2),
        .issue_o              (issue_o),
        .inst1_id_o           (inst1_id_o),
        .inst2_id_o           (inst2_id_o)
    );

endmodule

// File: hdu_properties.sv
/* concurrent assertions on the hazard unit top level, attached with bind */
`timescale 1ns/1ns

module hdu_properties #(
    parameter int ID_W = 3
) (
    input logic            clk,
    input logic            rst_n,
    input logic [1:0]      issue_o,
    input logic [ID_W-1:0] inst1_id_o,
    input logic [ID_W-1:0] inst2_id_o,
    input logic            inst1_wr,
    input logic            inst2_wr,
    input logic            lock_o
);

    int fail_cnt = 0;

    // inst2 never goes ahead of inst1
    a_in_order: assert property (@(posedge clk) disable iff (!rst_n) issue_o != 2'b10)
        else begin
            fail_cnt++;
            $error("issue_o granted inst2 alone");
        end

    a_lock_reset: assert property (@(posedge clk) !rst_n |-> !lock_o)
        else begin
            fail_cnt++;
            $error("lock_o high while in reset");
        end

    a_ids_differ: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_o == 2'b11 && inst1_wr && inst2_wr) |-> (inst1_id_o != inst2_id_o))
        else begin
            fail_cnt++;
            $error("both writes issued with slot ID %0d", inst1_id_o);
        end

endmodule

bind hdu_top hdu_properties #(.ID_W(ID_W)) i_hdu_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue_o    (issue_o),
    .inst1_id_o (inst1_id_o),
    .inst2_id_o (inst2_id_o),
    .inst1_wr   (inst1_wr),
    .inst2_wr   (inst2_wr),
    .lock_o     (lock_o)
);

// File: hdu_tb.sv
/* testbench for the dual-issue hazard unit; directed and random instruction pairs
   are compared every cycle with a reference copy of the slot table */
`timescale 1ns/1ns

module hdu_tb;

    localparam int NUM_SLOTS   = 8;
    localparam int ID_W        = $clog2(NUM_SLOTS);
    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 5;
    localparam int DIR_CYCLES  = 60;   // directed tests use about 35
    localparam int RAND_CYCLES = 300;

    logic               clk;
    logic               rst_n;
    logic               inst1_valid_i, inst1_rd_we_i, inst2_valid_i, inst2_rd_we_i;
    hdu_pkg::reg_addr_t inst1_rd_i, inst1_rs1_i, inst1_rs2_i;
    hdu_pkg::reg_addr_t inst2_rd_i, inst2_rs1_i, inst2_rs2_i;
    hdu_pkg::ex_unit_e  inst1_unit_i, inst2_unit_i;
    logic               commit_valid_i, commit2_valid_i;
    logic [ID_W-1:0]    commit_id_i, commit2_id_i;
    logic               irq_req_i, inst1_jump_i, inst1_branch_i;
    logic [1:0]         issue_o;
    logic [ID_W-1:0]    inst1_id_o, inst2_id_o;
    logic               lock_o;

    // reference slot table
    logic [NUM_SLOTS-1:0] m_occ;
    hdu_pkg::reg_addr_t   m_rd [NUM_SLOTS];
    hdu_pkg::ex_unit_e    m_unit [NUM_SLOTS];
    int                   checks = 0;
    int                   errors = 0;

    hdu_top #(.NUM_SLOTS(NUM_SLOTS)) i_hdu_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic writes(input logic valid, input logic we,
                                    input hdu_pkg::reg_addr_t rd);
        return valid && we && (rd != '0);
    endfunction

    // RAW on any real source, WAW only across unit classes
    function automatic logic conflicts(input int s, input logic valid, input logic wr,
                                       input hdu_pkg::reg_addr_t rd, rs1, rs2,
                                       input hdu_pkg::ex_unit_e unit);
        logic raw;
        raw = valid && ((rs1 != '0 && rs1 == m_rd[s]) || (rs2 != '0 && rs2 == m_rd[s]));
        return raw || (wr && rd == m_rd[s] && unit != m_unit[s]);
    endfunction

    // {lock_o, issue_o, inst1_id_o, inst2_id_o} for the inputs now applied
    function automatic logic [2*ID_W+2:0] expected_outputs();
        logic       w1, w2, haz1, haz2, pair, committing;
        logic [1:0] iss;
        int         nfree;
        int         f1;
        int         f2;
        w1    = writes(inst1_valid_i, inst1_rd_we_i, inst1_rd_i);
        w2    = writes(inst2_valid_i, inst2_rd_we_i, inst2_rd_i);
        haz1  = 1'b0;
        haz2  = 1'b0;
        nfree = 0;
        f1    = 0;
        f2    = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            committing = (commit_valid_i && commit_id_i == s) ||
                         (commit2_valid_i && commit2_id_i == s);
            if (m_occ[s] && !committing) begin
                haz1 |= conflicts(s, inst1_valid_i, w1, inst1_rd_i, inst1_rs1_i,
                                  inst1_rs2_i, inst1_unit_i);
                haz2 |= conflicts(s, inst2_valid_i, w2, inst2_rd_i, inst2_rs1_i,
                                  inst2_rs2_i, inst2_unit_i);
            end
            if (!m_occ[s]) begin
                f1 = (nfree == 0) ? s : f1;   // two lowest free slots
                f2 = (nfree == 1) ? s : f2;
                nfree++;
            end
        end
        pair = w1 && inst2_valid_i &&
               (inst2_rs1_i == inst1_rd_i || inst2_rs2_i == inst1_rd_i ||
                (w2 && inst2_rd_i == inst1_rd_i));
        if (nfree < 2 || irq_req_i || haz1) begin
            iss = 2'b00;
        end else if (inst1_jump_i || inst1_branch_i || haz2 || pair) begin
            iss = 2'b01;
        end else begin
            iss = 2'b11;
        end
        return {|m_occ, iss, ID_W'((iss[0] && inst1_valid_i) ? f1 : 0),
                ID_W'((iss[1] && inst2_valid_i) ? f2 : 0)};
    endfunction

    always @(posedge clk) begin
        logic            lock;
        logic [1:0]      iss;
        logic [ID_W-1:0] id1, id2;
        if (!rst_n) begin
            m_occ = '0;
        end else begin
            {lock, iss, id1, id2} = expected_outputs();
            if (commit_valid_i) m_occ[commit_id_i] = 1'b0;
            if (commit2_valid_i) m_occ[commit2_id_i] = 1'b0;
            // fill after clear, so it wins on a shared slot
            if (iss[0] && writes(inst1_valid_i, inst1_rd_we_i, inst1_rd_i)) begin
                m_occ[id1]  = 1'b1;
                m_rd[id1]   = inst1_rd_i;
                m_unit[id1] = inst1_unit_i;
            end
            if (iss[1] && writes(inst2_valid_i, inst2_rd_we_i, inst2_rd_i)) begin
                m_occ[id2]  = 1'b1;
                m_rd[id2]   = inst2_rd_i;
                m_unit[id2] = inst2_unit_i;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // compare every cycle, a quarter period after the inputs change
    always @(negedge clk) begin
        logic            lock;
        logic [1:0]      iss;
        logic [ID_W-1:0] id1, id2;
        #(CLK_PERIOD/4);
        if (rst_n) begin
            {lock, iss, id1, id2} = expected_outputs();
            check("issue_o", issue_o, iss);
            check("inst1_id_o", inst1_id_o, id1);
            check("inst2_id_o", inst2_id_o, id2);
            check("lock_o", lock_o, lock);
        end
    end

    task automatic drive_pair(input logic v1, input hdu_pkg::reg_addr_t rd1, src1,
                              input hdu_pkg::ex_unit_e u1, input logic v2,
                              input hdu_pkg::reg_addr_t rd2, src2,
                              input hdu_pkg::ex_unit_e u2);
        inst1_valid_i   = v1;
        inst1_rd_i      = rd1;
        inst1_rs1_i     = src1;
        inst1_rs2_i     = '0;
        inst1_rd_we_i   = 1'b1;
        inst1_unit_i    = u1;
        inst2_valid_i   = v2;
        inst2_rd_i      = rd2;
        inst2_rs1_i     = src2;
        inst2_rs2_i     = '0;
        inst2_rd_we_i   = 1'b1;
        inst2_unit_i    = u2;
        commit_valid_i  = 1'b0;
        commit_id_i     = '0;
        commit2_valid_i = 1'b0;
        commit2_id_i    = '0;
        irq_req_i       = 1'b0;
        inst1_jump_i    = 1'b0;
        inst1_branch_i  = 1'b0;
    endtask

    task automatic expect_issue(input logic [1:0] exp);
        #(CLK_PERIOD/4);
        check("issue_o", issue_o, exp);
        @(negedge clk);
    endtask

    task automatic commit_all();
        for (int s = 0; s < NUM_SLOTS; s += 2) begin
            drive_pair(1'b0, '0, '0, hdu_pkg::ALU, 1'b0, '0, '0, hdu_pkg::ALU);
            commit_valid_i  = 1'b1;
            commit_id_i     = ID_W'(s);
            commit2_valid_i = 1'b1;
            commit2_id_i    = ID_W'(s + 1);
            @(negedge clk);
        end
        check("lock_o", lock_o, 1'b0);
    endtask

    task automatic end_test(input string name);
        $display("test %-22s done, %0d errors so far", name, errors);
    endtask

    initial begin
        int   n;
        logic stalled;
        void'($urandom(60));
        rst_n = 1'b1;
        drive_pair(1'b0, '0, '0, hdu_pkg::ALU, 1'b0, '0, '0, hdu_pkg::ALU);
        #1 rst_n = 1'b0;   // clean falling edge for the async reset
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        drive_pair(1'b1, 5'd1, '0, hdu_pkg::ALU, 1'b1, 5'd2, '0, hdu_pkg::ALU);
        #(CLK_PERIOD/4);
        check("lock_o", lock_o, 1'b0);
        check("issue_o", issue_o, 2'b11);
        check("inst1_id_o", inst1_id_o, 0);
        check("inst2_id_o", inst2_id_o, 1);
        @(negedge clk);
        end_test("after reset");

        drive_pair(1'b1, 5'd5, '0, hdu_pkg::ALU, 1'b0, '0, '0, hdu_pkg::ALU);
        expect_issue(2'b11);   // r5 goes to slot 2
        drive_pair(1'b1, 5'd6, 5'd5, hdu_pkg::ALU, 1'b0, '0, '0, hdu_pkg::ALU);
        expect_issue(2'b00);
        drive_pair(1'b1, 5'd6, 5'd5, hdu_pkg::ALU, 1'b0, '0, '0, hdu_pkg::ALU);
        commit_valid_i = 1'b1;
        commit_id_i    = ID_W'(2);
        expect_issue(2'b11);
        commit_all();
        end_test("RAW stall and commit");

        drive_pair(1'b1, 5'd3, '0, hdu_pkg::ALU, 1'b1, 5'd4, 5'd3, hdu_pkg::ALU);
        expect_issue(2'b01);
        drive_pair(1'b1, 5'd7, '0, hdu_pkg::ALU, 1'b1, 5'd8, '0, hdu_pkg::ALU);
        inst1_jump_i = 1'b1;
        expect_issue(2'b01);
        drive_pair(1'b1, 5'd9, '0, hdu_pkg::ALU, 1'b1, 5'd10, '0, hdu_pkg::ALU);
        inst1_branch_i = 1'b1;
        expect_issue(2'b01);
        drive_pair(1'b1, 5'd11, '0, hdu_pkg::ALU, 1'b1, 5'd12, '0, hdu_pkg::ALU);
        irq_req_i = 1'b1;
        expect_issue(2'b00);
        commit_all();
        end_test("pair and serialization");

        drive_pair(1'b1, 5'd9, '0, hdu_pkg::MUL, 1'b0, '0, '0, hdu_pkg::ALU);
        expect_issue(2'b11);
        drive_pair(1'b1, 5'd9, '0, hdu_pkg::MUL, 1'b0, '0, '0, hdu_pkg::ALU);
        expect_issue(2'b11);   // same class retires in order
        drive_pair(1'b1, 5'd9, '0, hdu_pkg::DIV, 1'b0, '0, '0, hdu_pkg::ALU);
        expect_issue(2'b00);
        drive_pair(1'b1, 5'd0, '0, hdu_pkg::DIV, 1'b1, 5'd0, '0, hdu_pkg::LSU);
        expect_issue(2'b11);   // x0 is no dependency for inst2 either
        commit_all();
        end_test("WAW by unit class");

        n = 0;
        do begin
            drive_pair(1'b1, 5'(10 + 2 * n), '0, hdu_pkg::ALU,
                       1'b1, 5'(11 + 2 * n), '0, hdu_pkg::ALU);
            #(CLK_PERIOD/4);
            stalled = (issue_o == 2'b00);
            n++;
            @(negedge clk);
        end while (!stalled && n <= NUM_SLOTS);
        if (!stalled) begin
            errors++;
            $display("issue did not stall with the scoreboard full");
        end
        drive_pair(1'b1, 5'd30, '0, hdu_pkg::ALU, 1'b1, 5'd31, '0, hdu_pkg::ALU);
        commit_valid_i  = 1'b1;
        commit_id_i     = ID_W'(3);
        commit2_valid_i = 1'b1;
        commit2_id_i    = ID_W'(5);
        expect_issue(2'b00);   // credits only return at the edge
        drive_pair(1'b1, 5'd30, '0, hdu_pkg::ALU, 1'b1, 5'd31, '0, hdu_pkg::ALU);
        #(CLK_PERIOD/4);
        check("issue_o", issue_o, 2'b11);
        check("inst1_id_o", inst1_id_o, 3);
        check("inst2_id_o", inst2_id_o, 5);
        @(negedge clk);
        commit_all();
        end_test("credit exhaustion");

        for (int c = 0; c < RAND_CYCLES; c++) begin
            inst1_valid_i   = ($urandom % 4) != 0;
            inst1_rd_we_i   = ($urandom % 4) != 0;
            inst1_rd_i      = 5'($urandom % 8);   // few registers, many hazards
            inst1_rs1_i     = 5'($urandom % 8);
            inst1_rs2_i     = 5'($urandom % 8);
            inst1_unit_i    = hdu_pkg::ex_unit_e'($urandom % 5);
            inst2_valid_i   = ($urandom % 4) != 0;
            inst2_rd_we_i   = ($urandom % 4) != 0;
            inst2_rd_i      = 5'($urandom % 8);
            inst2_rs1_i     = 5'($urandom % 8);
            inst2_rs2_i     = 5'($urandom % 8);
            inst2_unit_i    = hdu_pkg::ex_unit_e'($urandom % 5);
            irq_req_i       = ($urandom % 16) == 0;
            inst1_jump_i    = ($urandom % 10) == 0;
            inst1_branch_i  = ($urandom % 10) == 0;
            commit_id_i     = ID_W'($urandom % NUM_SLOTS);
            commit_valid_i  = m_occ[commit_id_i] && ($urandom % 4 != 0);
            commit2_id_i    = ID_W'($urandom % NUM_SLOTS);
            commit2_valid_i = m_occ[commit2_id_i] && ($urandom % 4 != 0);
            @(negedge clk);
        end
        end_test("random traffic");

        errors += i_hdu_top.i_hdu_properties.fail_cnt;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #((RST_CYCLES + DIR_CYCLES + RAND_CYCLES + 100) * CLK_PERIOD);
        $display("timeout, the tests did not finish in the expected time");
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: hdu.f
hdu_pkg.sv
hdu_scoreboard.sv
hdu_slot_alloc.sv
hdu_hazard_check.sv
hdu_issue_ctrl.sv
hdu_top.sv
hdu_properties.sv
hdu_tb.sv
